// File: source/hazard_pkg.sv
package hazard_pkg;

  // architectural register file and data path widths
  localparam int num_regs   = 32;
  localparam int reg_addr_w = 5;
  localparam int xlen       = 32;

  // register block address space, byte offsets
  localparam int axil_addr_w = 4;
  localparam logic [axil_addr_w-1:0] reg_ctrl    = 4'h0;
  localparam logic [axil_addr_w-1:0] reg_cause   = 4'h4;
  localparam logic [axil_addr_w-1:0] reg_epc     = 4'h8;
  localparam logic [axil_addr_w-1:0] reg_badaddr = 4'hC;

  // AXI response code, the block never errors
  localparam logic [1:0] resp_okay = 2'b00;

  // mcause exception codes, subset raised at commit
  typedef enum logic [3:0] {
    insn_misaligned  = 4'd0,
    insn_fault       = 4'd1,
    illegal_insn     = 4'd2,
    breakpoint       = 4'd3,
    load_misaligned  = 4'd4,
    load_fault       = 4'd5,
    store_misaligned = 4'd6,
    store_fault      = 4'd7,
    ecall_m          = 4'd11
  } exc_cause_e;

  // instruction leaving decode toward the issue queues
  typedef struct packed {
    logic                  valid;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    logic                  wen;
    logic [1:0]            src_a_sel;
    logic [1:0]            src_b_sel;
  } dispatch_t;

  // result writeback from any functional unit
  typedef struct packed {
    logic                  valid;
    logic [reg_addr_w-1:0] rd;
  } wb_t;

  typedef struct packed {
    logic i_mem_busy;
    logic d_mem_busy;
    logic busy_ls;
    logic rob_full;
    logic jump;
    logic branch;
    logic mispredict;
  } pipe_status_t;

  // exception flags and addresses seen at the head of the ROB
  typedef struct packed {
    logic            fault_insn;
    logic            mal_insn;
    logic            illegal_insn;
    logic            breakpoint;
    logic            env_m;
    logic            mal_l;
    logic            fault_l;
    logic            mal_s;
    logic            fault_s;
    logic [xlen-1:0] epc;
    logic [xlen-1:0] badaddr_i;
    logic [xlen-1:0] badaddr_d;
  } commit_exc_t;

  typedef struct packed {
    logic pc_en;
    logic stall_fetch_decode;
    logic stall_ex;
    logic stall;
    logic npc_sel;
    logic pipe_clear;
    logic intr;
  } hazard_ctrl_t;

  typedef struct packed {
    logic            valid;
    exc_cause_e      cause;
    logic [xlen-1:0] epc;
    logic [xlen-1:0] badaddr;
  } trap_rec_t;

  typedef struct packed {
    logic [axil_addr_w-1:0] awaddr;
    logic                   awvalid;
    logic [xlen-1:0]        wdata;
    logic [xlen/8-1:0]      wstrb;
    logic                   wvalid;
    logic                   bready;
    logic [axil_addr_w-1:0] araddr;
    logic                   arvalid;
    logic                   rready;
  } axil_req_t;

  typedef struct packed {
    logic            awready;
    logic            wready;
    logic [1:0]      bresp;
    logic            bvalid;
    logic            arready;
    logic [xlen-1:0] rdata;
    logic [1:0]      rresp;
    logic            rvalid;
  } axil_rsp_t;

endpackage

// File: source/reg_scoreboard.sv
`timescale 1ns/1ps

module reg_scoreboard
  import hazard_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  dispatch_t disp,
  input  wb_t       wb,
  output logic      rs1_busy,
  output logic      rs2_busy,
  output logic      rd_busy
);

  // one bit per architectural register, high while a write is in flight
  logic [num_regs-1:0] busy;
  logic [num_regs-1:0] busy_nxt;

  // decoded set and clear masks for this cycle
  logic [num_regs-1:0] set_mask;
  logic [num_regs-1:0] clr_mask;

  always_comb begin
    set_mask = '0;
    clr_mask = '0;
    // x0 is hardwired, a write to it never creates a dependency
    if (disp.valid && disp.wen && (disp.rd != '0)) begin
      set_mask[disp.rd] = 1'b1;
    end
    if (wb.valid) begin
      clr_mask[wb.rd] = 1'b1;
    end
  end

  always_comb begin
    // clear first, then set, so a same-cycle set on one register wins
    busy_nxt    = (busy & ~clr_mask) | set_mask;
    busy_nxt[0] = 1'b0;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy <= '0;
    end else begin
      busy <= busy_nxt;
    end
  end

  // lookups use the registered state, so a dispatch sees
  // only producers from earlier cycles
  assign rs1_busy = busy[disp.rs1];
  assign rs2_busy = busy[disp.rs2];
  assign rd_busy  = busy[disp.rd];

  // x0 must stay free no matter what dispatch or writeback did
  a_x0_never_busy : assert property (
    @(posedge clk) disable iff (!rst_n)
    !busy[0]
  );

  // a register written back with no new producer is free next cycle
  a_wb_frees_reg : assert property (
    @(posedge clk) disable iff (!rst_n)
    (wb.valid && !(disp.valid && disp.wen && disp.rd == wb.rd))
      |=> !busy[$past(wb.rd)]
  );

endmodule

// File: source/ooo_hazard_unit.sv
`timescale 1ns/1ps

module ooo_hazard_unit
  import hazard_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  dispatch_t    disp,
  input  logic         rs1_busy,
  input  logic         rs2_busy,
  input  logic         rd_busy,
  input  pipe_status_t status,
  input  logic         exc_any,
  input  logic         intr_en,
  input  logic         sw_intr,
  input  logic         intr_taken,
  output hazard_ctrl_t ctrl
);

  // source operand selects 0 and 1 read the register file,
  // 2 and 3 take the pc or an immediate and need no producer
  function automatic logic src_busy(input logic [1:0] sel, input logic busy);
    logic reads_reg;
    reads_reg = (sel == 2'd0) || (sel == 2'd1);
    return reads_reg & busy;
  endfunction

  logic rs1_hazard;
  logic rs2_hazard;
  logic waw_hazard;
  logic data_hazard;
  logic mem_stall;
  logic branch_jump;
  logic intr_pend;

  assign rs1_hazard = src_busy(disp.src_a_sel, rs1_busy);
  assign rs2_hazard = src_busy(disp.src_b_sel, rs2_busy);

  // rd busy only matters when this instruction writes back too
  assign waw_hazard = rd_busy & disp.wen;

  assign data_hazard = rs1_hazard | rs2_hazard | waw_hazard;

  // load/store unit or data memory holding the back end
  assign mem_stall = status.d_mem_busy | status.busy_ls;

  // redirect on any jump or on a mispredicted branch
  assign branch_jump = status.jump | (status.branch & status.mispredict);

  // software interrupt request, enabled by the register block
  assign intr_pend = sw_intr & intr_en;

  always_comb begin
    // ROB full stalls every functional unit latch
    ctrl.stall_ex = status.rob_full;

    // front end holds on any back-end stall or operand dependency
    ctrl.stall_fetch_decode = ctrl.stall_ex | data_hazard;

    // pc only advances once fetch has its instruction and
    // decode is free to take the next one
    ctrl.pc_en = ~(status.i_mem_busy | ctrl.stall_fetch_decode | data_hazard);

    ctrl.stall = mem_stall | ctrl.stall_ex;

    ctrl.npc_sel = branch_jump;

    // exceptions at commit take precedence over a pending interrupt
    ctrl.intr = intr_pend & ~exc_any;

    // flush everything in flight on a trap or when the interrupt is taken
    ctrl.pipe_clear = exc_any | intr_taken;
  end

  // pc must hold while decode waits on a producer
  a_no_pc_on_hazard : assert property (
    @(posedge clk) disable iff (!rst_n)
    data_hazard |-> !ctrl.pc_en
  );

endmodule

// File: source/trap_recorder.sv
`timescale 1ns/1ps

module trap_recorder
  import hazard_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  commit_exc_t     exc,
  input  logic            trap_ack,
  output logic            exc_any,
  output trap_rec_t       rec,
  output logic [xlen-1:0] trap_count
);

  exc_cause_e      cause_sel;
  logic [xlen-1:0] badaddr_sel;

  // held record, valid kept apart from the payload
  logic            rec_valid;
  exc_cause_e      rec_cause;
  logic [xlen-1:0] rec_epc;
  logic [xlen-1:0] rec_badaddr;

  logic capture;

  assign exc_any = exc.fault_insn | exc.mal_insn | exc.illegal_insn |
                   exc.breakpoint | exc.env_m | exc.mal_l | exc.fault_l |
                   exc.mal_s | exc.fault_s;

  // synchronous exception priority, highest first
  always_comb begin
    cause_sel   = store_fault;
    badaddr_sel = exc.badaddr_d;
    if (exc.breakpoint) begin
      cause_sel   = breakpoint;
      badaddr_sel = '0;
    end else if (exc.fault_insn) begin
      cause_sel   = insn_fault;
      badaddr_sel = exc.badaddr_i;
    end else if (exc.mal_insn) begin
      cause_sel   = insn_misaligned;
      badaddr_sel = exc.badaddr_i;
    end else if (exc.illegal_insn) begin
      cause_sel   = illegal_insn;
      badaddr_sel = '0;
    end else if (exc.env_m) begin
      cause_sel   = ecall_m;
      badaddr_sel = '0;
    end else if (exc.mal_s) begin
      cause_sel = store_misaligned;
    end else if (exc.mal_l) begin
      cause_sel = load_misaligned;
    end else if (exc.fault_s) begin
      cause_sel = store_fault;
    end else if (exc.fault_l) begin
      cause_sel = load_fault;
    end
  end

  // only the first trap is kept until software acknowledges it
  assign capture = exc_any & ~rec_valid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rec_valid  <= 1'b0;
      trap_count <= '0;
    end else begin
      if (rec_valid && trap_ack) begin
        rec_valid <= 1'b0;
      end else if (capture) begin
        rec_valid <= 1'b1;
      end
      // every exception cycle is counted, recorded or not
      if (exc_any) begin
        trap_count <= trap_count + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      rec_cause   <= cause_sel;
      rec_epc     <= exc.epc;
      rec_badaddr <= badaddr_sel;
    end
  end

  assign rec.valid   = rec_valid;
  assign rec.cause   = rec_cause;
  assign rec.epc     = rec_epc;
  assign rec.badaddr = rec_badaddr;

  // a held record is frozen until it is acknowledged
  a_rec_frozen : assert property (
    @(posedge clk) disable iff (!rst_n)
    rec_valid |=> $stable(rec_cause)
  );

endmodule

// File: source/hazard_cfg_axil.sv
`timescale 1ns/1ps

module hazard_cfg_axil
  import hazard_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  axil_req_t       axil_req,
  output axil_rsp_t       axil_rsp,
  input  trap_rec_t       rec,
  input  logic [xlen-1:0] trap_count,
  output logic            intr_en,
  output logic            sw_intr,
  output logic            trap_ack
);

  logic wr_hs;
  logic rd_hs;

  logic            bvalid_q;
  logic            rvalid_q;
  logic [xlen-1:0] rdata_q;
  logic [xlen-1:0] rd_mux;

  // trap count as seen in the upper half of the control register
  logic [15:0] count_sat;

  // address and data must arrive together, one write in flight at a time
  assign wr_hs = axil_req.awvalid & axil_req.wvalid & ~bvalid_q;

  // one read in flight, the next waits for rready
  assign rd_hs = axil_req.arvalid & ~rvalid_q;

  assign axil_rsp.awready = wr_hs;
  assign axil_rsp.wready  = wr_hs;
  assign axil_rsp.arready = rd_hs;
  assign axil_rsp.bvalid  = bvalid_q;
  assign axil_rsp.bresp   = resp_okay;
  assign axil_rsp.rvalid  = rvalid_q;
  assign axil_rsp.rdata   = rdata_q;
  assign axil_rsp.rresp   = resp_okay;

  // any write to the cause register releases the held trap record
  assign trap_ack = wr_hs & (axil_req.awaddr == reg_cause);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      intr_en <= 1'b0;
      sw_intr <= 1'b0;
    end else if (wr_hs && (axil_req.awaddr == reg_ctrl) && axil_req.wstrb[0]) begin
      intr_en <= axil_req.wdata[0];
      sw_intr <= axil_req.wdata[1];
    end
  end

  // write response
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bvalid_q <= 1'b0;
    end else if (wr_hs) begin
      bvalid_q <= 1'b1;
    end else if (axil_req.bready) begin
      bvalid_q <= 1'b0;
    end
  end

  assign count_sat = (|trap_count[xlen-1:16]) ? 16'hFFFF : trap_count[15:0];

  always_comb begin
    case (axil_req.araddr)
      reg_ctrl:    rd_mux = {count_sat, 14'b0, sw_intr, intr_en};
      reg_cause:   rd_mux = {rec.valid, 27'b0, rec.cause};
      reg_epc:     rd_mux = rec.epc;
      reg_badaddr: rd_mux = rec.badaddr;
      // unmapped offsets read as zero
      default:     rd_mux = '0;
    endcase
  end

  // read response, data held steady while rvalid waits on rready
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rvalid_q <= 1'b0;
    end else if (rd_hs) begin
      rvalid_q <= 1'b1;
    end else if (axil_req.rready) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_hs) begin
      rdata_q <= rd_mux;
    end
  end

  // write response must not be withdrawn before the master takes it
  a_bvalid_held : assert property (
    @(posedge clk) disable iff (!rst_n)
    (bvalid_q && !axil_req.bready) |=> bvalid_q
  );

  // same for read data, which must also stay unchanged
  a_rdata_held : assert property (
    @(posedge clk) disable iff (!rst_n)
    (rvalid_q && !axil_req.rready) |=> (rvalid_q && $stable(rdata_q))
  );

endmodule

// File: source/ooo_hazard_top.sv
`timescale 1ns/1ps

module ooo_hazard_top
  import hazard_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  dispatch_t    disp,
  input  wb_t          wb,
  input  pipe_status_t status,
  input  commit_exc_t  exc,
  input  logic         intr_taken,
  input  axil_req_t    axil_req,
  output hazard_ctrl_t ctrl,
  output axil_rsp_t    axil_rsp
);

  logic            rs1_busy;
  logic            rs2_busy;
  logic            rd_busy;
  logic            exc_any;
  logic            intr_en;
  logic            sw_intr;
  logic            trap_ack;
  trap_rec_t       rec;
  logic [xlen-1:0] trap_count;

  reg_scoreboard u_scoreboard (
    .clk      (clk),
    .rst_n    (rst_n),
    .disp     (disp),
    .wb       (wb),
    .rs1_busy (rs1_busy),
    .rs2_busy (rs2_busy),
    .rd_busy  (rd_busy)
  );

  ooo_hazard_unit u_hazard (
    .clk        (clk),
    .rst_n      (rst_n),
    .disp       (disp),
    .rs1_busy   (rs1_busy),
    .rs2_busy   (rs2_busy),
    .rd_busy    (rd_busy),
    .status     (status),
    .exc_any    (exc_any),
    .intr_en    (intr_en),
    .sw_intr    (sw_intr),
    .intr_taken (intr_taken),
    .ctrl       (ctrl)
  );

  trap_recorder u_trap (
    .clk        (clk),
    .rst_n      (rst_n),
    .exc        (exc),
    .trap_ack   (trap_ack),
    .exc_any    (exc_any),
    .rec        (rec),
    .trap_count (trap_count)
  );

  hazard_cfg_axil u_cfg (
    .clk        (clk),
    .rst_n      (rst_n),
    .axil_req   (axil_req),
    .axil_rsp   (axil_rsp),
    .rec        (rec),
    .trap_count (trap_count),
    .intr_en    (intr_en),
    .sw_intr    (sw_intr),
    .trap_ack   (trap_ack)
  );

endmodule

// File: test/tb_ooo_hazard.sv
`timescale 1ns/1ps

module tb_ooo_hazard
  import hazard_pkg::*;
();

  localparam int hs_timeout = 64;

  logic         clk;
  logic         rst_n;
  dispatch_t    disp;
  wb_t          wb;
  pipe_status_t status;
  commit_exc_t  exc;
  logic         intr_taken;
  axil_req_t    axil_req;
  hazard_ctrl_t ctrl;
  axil_rsp_t    axil_rsp;

  // expected state built only from what the testbench drove
  logic [num_regs-1:0] model_busy;
  logic [num_regs-1:0] busy_next;
  logic                model_ie;
  logic                model_sip;
  int                  exc_cycles;
  int                  seed = 28;

  // flag order fault_insn mal_insn illegal brk ecall mal_l fault_l mal_s fault_s
  logic [8:0]  prio_cases [9];
  logic [31:0] rnd;
  logic [31:0] rdata;
  trap_rec_t   rec_a;
  trap_rec_t   rec_b;

  ooo_hazard_top DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .disp       (disp),
    .wb         (wb),
    .status     (status),
    .exc        (exc),
    .intr_taken (intr_taken),
    .axil_req   (axil_req),
    .ctrl       (ctrl),
    .axil_rsp   (axil_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic any_exc(input commit_exc_t e);
    return e.fault_insn | e.mal_insn | e.illegal_insn | e.breakpoint | e.env_m |
           e.mal_l | e.fault_l | e.mal_s | e.fault_s;
  endfunction

  // valid dispatch reading rs1 through sel_a, rs2 side uses an immediate
  function automatic dispatch_t make_disp(input logic [4:0] rs1, input logic [4:0] rd,
                                          input logic wen, input logic [1:0] sel_a);
    dispatch_t d;
    d           = '0;
    d.valid     = 1'b1;
    d.rs1       = rs1;
    d.rd        = rd;
    d.wen       = wen;
    d.src_a_sel = sel_a;
    d.src_b_sel = 2'd2;
    return d;
  endfunction

  function automatic hazard_ctrl_t ref_ctrl(input dispatch_t d, input pipe_status_t s,
                                            input logic [31:0] busy, input logic exc_set,
                                            input logic ie, input logic sip,
                                            input logic taken);
    hazard_ctrl_t c;
    logic         dh;
    // selects 2 and 3 have top bit set and read no register
    dh = (busy[d.rs1] & ~d.src_a_sel[1]) | (busy[d.rs2] & ~d.src_b_sel[1]) |
         (busy[d.rd] & d.wen);
    c.stall_ex           = s.rob_full;
    c.stall_fetch_decode = s.rob_full | dh;
    c.pc_en              = ~(s.i_mem_busy | s.rob_full | dh);
    c.stall              = s.d_mem_busy | s.busy_ls | s.rob_full;
    c.npc_sel            = s.jump | (s.branch & s.mispredict);
    c.intr               = sip & ie & ~exc_set;
    c.pipe_clear         = exc_set | taken;
    return c;
  endfunction

  function automatic trap_rec_t ref_trap(input commit_exc_t e);
    trap_rec_t  r;
    logic [8:0] pri;
    logic [3:0] code_by_rank [9];
    code_by_rank = '{4'd3, 4'd1, 4'd0, 4'd2, 4'd11, 4'd6, 4'd4, 4'd7, 4'd5};
    // rank 0 is breakpoint, the highest priority
    pri = {e.fault_l, e.fault_s, e.mal_l, e.mal_s, e.env_m, e.illegal_insn,
           e.mal_insn, e.fault_insn, e.breakpoint};
    r       = '0;
    r.valid = 1'b1;
    r.epc   = e.epc;
    // walk up from the lowest rank so the top flag lands last
    for (int i = 8; i >= 0; i--) begin
      if (pri[i]) begin
        r.cause = exc_cause_e'(code_by_rank[i]);
        if (i == 1 || i == 2) begin
          r.badaddr = e.badaddr_i;
        end else if (i <= 4) begin
          r.badaddr = '0;
        end else begin
          r.badaddr = e.badaddr_d;
        end
      end
    end
    return r;
  endfunction

  task automatic abort_run();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s got 0x%08h expected 0x%08h", $time, msg, got, exp);
      abort_run();
    end
  endtask

  task automatic handshake_timeout(input string what);
    $display("timeout at %0t ns waiting for %s", $time, what);
    abort_run();
  endtask

  // bp is the number of cycles bready stays low once bvalid is up
  task automatic axil_write(input logic [axil_addr_w-1:0] addr, input logic [31:0] data,
                            input int bp);
    int n;
    @(posedge clk);
    axil_req.awaddr  <= addr;
    axil_req.awvalid <= 1'b1;
    axil_req.wdata   <= data;
    axil_req.wstrb   <= 4'hF;
    axil_req.wvalid  <= 1'b1;
    axil_req.bready  <= 1'b0;
    @(negedge clk);
    n = 0;
    while (!axil_rsp.awready) begin
      @(negedge clk);
      n++;
      if (n >= hs_timeout) handshake_timeout("awready");
    end
    n = 0;
    while (!axil_rsp.wready) begin
      @(negedge clk);
      n++;
      if (n >= hs_timeout) handshake_timeout("wready");
    end
    @(posedge clk);
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
    // control bits take the new value on this edge
    if (addr == reg_ctrl) begin
      model_ie  = data[0];
      model_sip = data[1];
    end
    @(negedge clk);
    n = 0;
    while (!axil_rsp.bvalid) begin
      @(negedge clk);
      n++;
      if (n >= hs_timeout) handshake_timeout("bvalid");
    end
    check(32'(axil_rsp.bresp), 32'(resp_okay), "write response code");
    repeat (bp) begin
      @(negedge clk);
      check(32'(axil_rsp.bvalid), 32'd1, "bvalid dropped while bready low");
    end
    @(posedge clk);
    axil_req.bready <= 1'b1;
    @(posedge clk);
    axil_req.bready <= 1'b0;
  endtask

  task automatic axil_read(input logic [axil_addr_w-1:0] addr, input int hold,
                           output logic [31:0] data);
    int          n;
    logic [31:0] first;
    @(posedge clk);
    axil_req.araddr  <= addr;
    axil_req.arvalid <= 1'b1;
    axil_req.rready  <= 1'b0;
    @(negedge clk);
    n = 0;
    while (!axil_rsp.arready) begin
      @(negedge clk);
      n++;
      if (n >= hs_timeout) handshake_timeout("arready");
    end
    @(posedge clk);
    axil_req.arvalid <= 1'b0;
    // point araddr at another register while the response is held
    axil_req.araddr  <= addr ^ 4'h8;
    @(negedge clk);
    n = 0;
    while (!axil_rsp.rvalid) begin
      @(negedge clk);
      n++;
      if (n >= hs_timeout) handshake_timeout("rvalid");
    end
    check(32'(axil_rsp.rresp), 32'(resp_okay), "read response code");
    first = axil_rsp.rdata;
    repeat (hold) begin
      @(negedge clk);
      check(32'(axil_rsp.rvalid), 32'd1, "rvalid dropped while rready low");
      check(axil_rsp.rdata, first, "rdata changed while rready low");
    end
    @(posedge clk);
    axil_req.rready <= 1'b1;
    @(posedge clk);
    axil_req.rready <= 1'b0;
    data = first;
  endtask

  // one commit cycle with the given flags and random addresses
  task automatic inject_exc(input logic [8:0] flags, output trap_rec_t exp_rec);
    commit_exc_t e;
    e = '0;
    {e.fault_insn, e.mal_insn, e.illegal_insn, e.breakpoint, e.env_m,
     e.mal_l, e.fault_l, e.mal_s, e.fault_s} = flags;
    e.epc       = $random(seed);
    e.badaddr_i = $random(seed);
    e.badaddr_d = $random(seed);
    exp_rec     = ref_trap(e);
    @(posedge clk);
    exc <= e;
    exc_cycles++;
    @(negedge clk);
    check(32'(ctrl.pipe_clear), 32'd1, "pipe_clear on commit exception");
    check(32'(ctrl.intr), 32'd0, "intr during commit exception");
    @(posedge clk);
    exc <= '0;
  endtask

  task automatic check_record(input trap_rec_t exp_rec, input string what);
    logic [31:0] rd;
    axil_read(reg_cause, 0, rd);
    check(rd, {exp_rec.valid, 27'b0, exp_rec.cause}, {what, " cause"});
    axil_read(reg_epc, 0, rd);
    check(rd, exp_rec.epc, {what, " epc"});
    axil_read(reg_badaddr, 0, rd);
    check(rd, exp_rec.badaddr, {what, " badaddr"});
  endtask

  task automatic ack_trap();
    logic [31:0] rd;
    axil_write(reg_cause, 32'h0, 0);
    axil_read(reg_cause, 0, rd);
    check(32'(rd[31]), 32'd0, "record still valid after acknowledge");
  endtask

  // scoreboard model, clear then set so a same-cycle set wins
  always @(posedge clk) begin
    if (!rst_n) begin
      model_busy <= '0;
    end else begin
      busy_next = model_busy;
      if (wb.valid) busy_next[wb.rd] = 1'b0;
      if (disp.valid && disp.wen) busy_next[disp.rd] = 1'b1;
      busy_next[0] = 1'b0;
      model_busy <= busy_next;
    end
  end

  // ctrl is combinational so the mid-cycle value is settled
  always @(negedge clk) begin
    if (rst_n) begin
      check({25'b0, ctrl},
            {25'b0, ref_ctrl(disp, status, model_busy, any_exc(exc), model_ie, model_sip,
                             intr_taken)},
            "hazard control word");
    end
  end

  initial begin
    rst_n      <= 1'b0;
    disp       <= '0;
    wb         <= '0;
    status     <= '0;
    exc        <= '0;
    intr_taken <= 1'b0;
    axil_req   <= '0;
    model_ie   = 1'b0;
    model_sip  = 1'b0;
    exc_cycles = 0;
    prio_cases = '{9'b001101000, 9'b110000001, 9'b011000000, 9'b001010100, 9'b000010010,
                   9'b000001110, 9'b000001001, 9'b000000101, 9'b000000100};
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    axil_read(reg_ctrl, 0, rdata);
    check(rdata, 32'h0, "reg_ctrl after reset");
    axil_read(reg_cause, 0, rdata);
    check(32'(rdata[31]), 32'd0, "trap record valid after reset");

    // RAW on x5
    @(posedge clk);
    disp <= make_disp(5'd0, 5'd5, 1'b1, 2'd2);
    @(posedge clk);
    disp <= make_disp(5'd5, 5'd0, 1'b0, 2'd0);
    @(negedge clk);
    check(32'(ctrl.stall_fetch_decode), 32'd1, "read of busy x5 must stall decode");
    check(32'(ctrl.pc_en), 32'd0, "read of busy x5 must hold pc");
    @(posedge clk);
    disp <= make_disp(5'd5, 5'd0, 1'b0, 2'd2);
    @(negedge clk);
    check(32'(ctrl.stall_fetch_decode), 32'd0, "x5 behind select 2 needs no stall");
    @(posedge clk);
    disp <= make_disp(5'd5, 5'd0, 1'b0, 2'd0);
    wb   <= '{valid: 1'b1, rd: 5'd5};
    @(negedge clk);
    check(32'(ctrl.stall_fetch_decode), 32'd1, "x5 still busy in its writeback cycle");
    @(posedge clk);
    wb <= '0;
    @(negedge clk);
    check(32'(ctrl.stall_fetch_decode), 32'd0, "x5 free one cycle after writeback");

    // random pipeline traffic, the compare process checks every cycle
    repeat (300) begin
      @(posedge clk);
      rnd = $random(seed);
      disp       <= dispatch_t'(rnd[20:0]);
      rnd = $random(seed);
      wb         <= wb_t'(rnd[5:0]);
      status     <= pipe_status_t'(rnd[12:6]);
      intr_taken <= rnd[13];
    end
    @(posedge clk);
    disp       <= '0;
    wb         <= '0;
    status     <= '0;
    intr_taken <= 1'b0;

    // several flags per commit cycle
    foreach (prio_cases[i]) begin
      inject_exc(prio_cases[i], rec_a);
      check_record(rec_a, "priority case");
      ack_trap();
    end

    // hold while valid then acknowledge and record again
    inject_exc(9'b000000100, rec_a);
    inject_exc(9'b000100000, rec_b);
    check_record(rec_a, "held record");
    ack_trap();
    inject_exc(9'b001000000, rec_b);
    check_record(rec_b, "record after acknowledge");
    ack_trap();
    axil_read(reg_ctrl, 0, rdata);
    check(32'(rdata[31:16]), 32'(exc_cycles[15:0]), "trap count");

    // interrupt gating
    axil_write(reg_ctrl, 32'h1, 0);
    @(negedge clk);
    check(32'(ctrl.intr), 32'd0, "intr without a pending request");
    axil_write(reg_ctrl, 32'h3, 0);
    @(negedge clk);
    check(32'(ctrl.intr), 32'd1, "intr with enable and pending set");
    inject_exc(9'b001000000, rec_a);
    ack_trap();
    @(posedge clk);
    intr_taken <= 1'b1;
    @(negedge clk);
    check(32'(ctrl.pipe_clear), 32'd1, "pipe_clear on intr_taken");
    @(posedge clk);
    intr_taken <= 1'b0;
    axil_write(reg_ctrl, 32'h2, 0);
    @(negedge clk);
    check(32'(ctrl.intr), 32'd0, "intr pending but disabled");

    // responses stalled by the master for random stretches
    repeat (6) begin
      rnd = $random(seed);
      axil_write(reg_ctrl, {30'b0, rnd[1:0]}, int'(rnd[4:2]) + 1);
      axil_read(reg_ctrl, int'(rnd[7:5]) + 1, rdata);
      check(rdata, {exc_cycles[15:0], 14'b0, model_sip, model_ie},
            "reg_ctrl readback under back-pressure");
    end
    axil_write(reg_ctrl, 32'h0, 0);

    $display("Everything OK");
    $finish;
  end

endmodule

// File: ooo_hazard.f
source/hazard_pkg.sv
source/reg_scoreboard.sv
source/ooo_hazard_unit.sv
source/trap_recorder.sv
source/hazard_cfg_axil.sv
source/ooo_hazard_top.sv
test/tb_ooo_hazard.sv

// File: Makefile
TOP := tb_ooo_hazard

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -j 0 -f ooo_hazard.f --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Everything OK"

lint:
	verilator --lint-only --timing -f ooo_hazard.f --top-module ooo_hazard_top

clean:
	rm -rf obj_dir
